//--- mbistRepair.f
+incdir+include
logic/mbist_pkg.sv
logic/marchSequencer.sv
logic/readCompare.sv
logic/repairMap.sv
logic/mbistTop.sv
bench/repairChecker.sv
bench/tbTop.sv

//--- Bender.yml
package:
  name: mbistRepair

sources:
  - include_dirs:
      - include
    files:
      - logic/mbist_pkg.sv
      - logic/marchSequencer.sv
      - logic/readCompare.sv
      - logic/repairMap.sv
      - logic/mbistTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/repairChecker.sv
      - bench/tbTop.sv

//--- bench/tbTop.sv
// MBIST testbench
// Clock, reset, SRAM model with random stuck-at faults and the test
// sequence around the MBIST top level

`timescale 1ns/100ps
`default_nettype none

`include "mbist_consts.svh"

module tbTop import mbist_pkg::*; ();

   localparam int         rowNum        = 1 << `MBIST_ADDR_WD;
   localparam int         timeoutCycles = 4000;
   // Bit held low by a stuck-at-0 fault
   localparam int         sa0Bit        = 13;
   localparam logic [1:0] kindReset     = 2'd0;
   localparam logic [1:0] kindStatus    = 2'd1;
   localparam logic [1:0] kindScan      = 2'd2;

   logic              clk;
   logic              rst_n;
   logic              bistStart;
   logic              bistDone;
   logic              repairable;
   slotCnt_t          usedSlots;
   memCmd_t           funcCmd;
   memCmd_t           memCmd;
   bistData_t         memRdata;
   logic              scanLoad;
   logic              scanShift;
   logic              scanIn;
   logic              scanOut;
   bistData_t         mem [rowNum];
   logic [rowNum-1:0] sa1Mask;
   logic [rowNum-1:0] sa0Mask;
   logic              checkReq;
   logic [1:0]        checkKind;
   logic              timedOut;
   int                testsRun;
   int                testsFailed;
   int                errTotal;

   always #2 clk = ~clk;

   mbistTop dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .bistStart  (bistStart),
      .bistDone   (bistDone),
      .repairable (repairable),
      .usedSlots  (usedSlots),
      .funcCmd    (funcCmd),
      .memCmd     (memCmd),
      .memRdata   (memRdata),
      .scanLoad   (scanLoad),
      .scanShift  (scanShift),
      .scanIn     (scanIn),
      .scanOut    (scanOut)
   );

   repairChecker chk (
      .clk         (clk),
      .rst_n       (rst_n),
      .bistStart   (bistStart),
      .bistDone    (bistDone),
      .repairable  (repairable),
      .usedSlots   (usedSlots),
      .funcCmd     (funcCmd),
      .memCmd      (memCmd),
      .scanShift   (scanShift),
      .scanOut     (scanOut),
      .sa1Mask     (sa1Mask),
      .sa0Mask     (sa0Mask),
      .checkReq    (checkReq),
      .checkKind   (checkKind),
      .testsRun    (testsRun),
      .testsFailed (testsFailed),
      .errTotal    (errTotal)
   );

   ////////////////////////////////////////////////////////////////////////////
   // SRAM model, read data one cycle after the command
   ////////////////////////////////////////////////////////////////////////////

   function automatic bistData_t faultyRead(input bistAddr_t a);
      bistData_t d;
      d = mem[a];
      if (sa1Mask[a]) d[0] = 1'b1;
      if (sa0Mask[a]) d[sa0Bit] = 1'b0;
      return d;
   endfunction

   always @(posedge clk) begin
      if (memCmd.en && memCmd.we) begin
         mem[memCmd.addr] <= memCmd.wdata;
      end else if (memCmd.en) begin
         memRdata <= faultyRead(memCmd.addr);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////////////////////

   // Distinct rows in the tested range, random fault kind each
   task automatic injectFaults(input int count);
      logic [rowNum-1:0] newSa1;
      logic [rowNum-1:0] newSa0;
      bistAddr_t         a;
      int                placed;
      newSa1 = '0;
      newSa0 = '0;
      placed = 0;
      while (placed < count) begin
         a = bistAddr_t'($urandom_range(`MBIST_ADDR_END, 0));
         if (!newSa1[a] && !newSa0[a]) begin
            if ($urandom_range(1, 0) == 1) newSa1[a] = 1'b1;
            else newSa0[a] = 1'b1;
            placed++;
         end
      end
      @(posedge clk);
      sa1Mask <= newSa1;
      sa0Mask <= newSa0;
   endtask

   task automatic waitForDone();
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!bistDone && waited < timeoutCycles);
      if (!bistDone) begin
         $display("Timed out after %0d cycles waiting for bistDone", waited);
         timedOut = 1'b1;
      end
   endtask

   // Optional second start pulse while the test is running
   task automatic runBist(input int midDelay);
      @(posedge clk);
      bistStart <= 1'b1;
      @(posedge clk);
      bistStart <= 1'b0;
      if (midDelay > 0) begin
         repeat (midDelay) @(posedge clk);
         bistStart <= 1'b1;
         @(posedge clk);
         bistStart <= 1'b0;
      end
      waitForDone();
   endtask

   task automatic driveFunc(input bistAddr_t a);
      memCmd_t cmd;
      cmd.en    = 1'b1;
      cmd.we    = 1'($urandom_range(1, 0));
      cmd.addr  = a;
      cmd.wdata = $urandom;
      @(posedge clk);
      funcCmd <= cmd;
   endtask

   // Every faulty row, then a few random rows including spares
   task automatic funcSweep();
      for (int a = 0; a < rowNum; a++) begin
         if (sa1Mask[a] || sa0Mask[a]) driveFunc(bistAddr_t'(a));
      end
      repeat (16) driveFunc(bistAddr_t'($urandom_range(rowNum - 1, 0)));
      @(posedge clk);
      funcCmd <= '0;
   endtask

   task automatic scanUnload();
      @(posedge clk);
      scanLoad <= 1'b1;
      @(posedge clk);
      scanLoad  <= 1'b0;
      scanShift <= 1'b1;
      repeat (`MBIST_ERR_LIMIT * `MBIST_ADDR_WD) @(posedge clk);
      scanShift <= 1'b0;
   endtask

   // Checker closes the test on the negedge in between
   task automatic checkpoint(input logic [1:0] kind);
      @(posedge clk);
      checkKind <= kind;
      checkReq  <= 1'b1;
      @(posedge clk);
      checkReq  <= 1'b0;
   endtask

   task automatic runTests();
      checkpoint(kindReset);
      // Clean memory
      runBist(0);
      if (timedOut) return;
      funcSweep();
      checkpoint(kindStatus);
      // One to four faults, then unload that record
      injectFaults($urandom_range(4, 1));
      runBist(0);
      if (timedOut) return;
      funcSweep();
      checkpoint(kindStatus);
      scanUnload();
      checkpoint(kindScan);
      // More faults than spare rows
      injectFaults(6);
      runBist(0);
      if (timedOut) return;
      funcSweep();
      checkpoint(kindStatus);
      // New faults, start pulse in the middle of the run
      injectFaults($urandom_range(4, 1));
      runBist(700);
      if (timedOut) return;
      funcSweep();
      checkpoint(kindStatus);
      scanUnload();
      checkpoint(kindScan);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      bistStart = 1'b0;
      funcCmd   = '0;
      memRdata  = '0;
      scanLoad  = 1'b0;
      scanShift = 1'b0;
      scanIn    = 1'b0;
      sa1Mask   = '0;
      sa0Mask   = '0;
      checkReq  = 1'b0;
      checkKind = kindReset;
      timedOut  = 1'b0;
      void'($urandom(44));
      // Fill that differs in every address bit
      for (int i = 0; i < rowNum; i++) begin
         mem[i] = bistData_t'(i) * 32'h9E3779B1;
      end
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      runTests();
      @(posedge clk);
      $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errTotal);
      if (timedOut || testsFailed != 0 || errTotal != 0) begin
         $display("Verification failed");
      end else begin
         $display("Verification passed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/repairChecker.sv
// Repair checker
// Predicts the repair record from the injected faults, watches the
// DUT ports and reports every mismatch with a line per finished test

`timescale 1ns/100ps
`default_nettype none

`include "mbist_consts.svh"

module repairChecker import mbist_pkg::*; (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           bistStart,
   input  logic                           bistDone,
   input  logic                           repairable,
   input  slotCnt_t                       usedSlots,
   input  memCmd_t                        funcCmd,
   input  memCmd_t                        memCmd,
   input  logic                           scanShift,
   input  logic                           scanOut,
   input  logic [(1<<`MBIST_ADDR_WD)-1:0] sa1Mask,
   input  logic [(1<<`MBIST_ADDR_WD)-1:0] sa0Mask,
   input  logic                           checkReq,
   input  logic [1:0]                     checkKind,
   output int                             testsRun,
   output int                             testsFailed,
   output int                             errTotal
);

   localparam logic [1:0] kindReset  = 2'd0;
   localparam logic [1:0] kindStatus = 2'd1;
   localparam int         chainWd    = `MBIST_ERR_LIMIT * `MBIST_ADDR_WD;
   // Start edge, then six cycles per row over the four elements, then drain
   localparam int         runLength  = 1 + 6 * (`MBIST_ADDR_END + 1) + 3;

   bistAddr_t [`MBIST_ERR_LIMIT-1:0] predSlots;
   slotCnt_t                         predCount;
   logic                             predRepairable;
   logic [chainWd-1:0]               scanBits;
   logic                             runBusy;
   int                               runCycles;
   int                               testErrs;

   initial begin
      testsRun    = 0;
      testsFailed = 0;
      errTotal    = 0;
      testErrs    = 0;
      runBusy     = 1'b0;
      runCycles   = 0;
      scanBits    = '0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Prediction
   ////////////////////////////////////////////////////////////////////////////

   // Next failing row takes a free slot, or marks the memory beyond repair
   task automatic keepPrediction(input bistAddr_t a);
      if (predCount < slotCnt_t'(`MBIST_ERR_LIMIT)) begin
         predSlots[predCount[1:0]] = a;
         predCount++;
      end else begin
         predRepairable = 1'b0;
      end
   endtask

   // Stuck-at-1 rows fail on the way up, stuck-at-0 rows on the way down
   task automatic predictRecord();
      predSlots      = '0;
      predCount      = '0;
      predRepairable = 1'b1;
      for (int a = 0; a <= `MBIST_ADDR_END; a++) begin
         if (sa1Mask[a]) keepPrediction(bistAddr_t'(a));
      end
      // Rows already seen on the way up are duplicates
      for (int a = `MBIST_ADDR_END; a >= 0; a--) begin
         if (sa0Mask[a] && !sa1Mask[a]) keepPrediction(bistAddr_t'(a));
      end
   endtask

   function automatic bistAddr_t expectedAddr(input bistAddr_t a);
      bistAddr_t m;
      logic      found;
      m     = a;
      found = 1'b0;
      for (int i = 0; i < int'(predCount); i++) begin
         if (!found && predSlots[i] == a) begin
            m     = `MBIST_REPAIR_BASE + bistAddr_t'(i);
            found = 1'b1;
         end
      end
      return m;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Reporting
   ////////////////////////////////////////////////////////////////////////////

   task automatic checkValue(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         testErrs++;
      end
   endtask

   function automatic string testLabel(input int n);
      case (n)
         1:       return "reset state";
         2:       return "no faults";
         3:       return "up to four faults";
         4:       return "scan unload";
         5:       return "six faults";
         6:       return "rerun with new faults";
         7:       return "scan after rerun";
         default: return "extra";
      endcase
   endfunction

   task automatic closeTest();
      predictRecord();
      case (checkKind)
         kindReset: begin
            checkValue("bistDone", bistDone, 64'd0);
            checkValue("usedSlots", usedSlots, 64'd0);
            checkValue("memCmd.en", memCmd.en, 64'd0);
         end
         kindStatus: begin
            checkValue("bistDone", bistDone, 64'd1);
            checkValue("repairable", repairable, predRepairable);
            checkValue("usedSlots", usedSlots, predCount);
         end
         // Slot 3 leaves first
         default: checkValue("scanOut", scanBits, predSlots);
      endcase
      testsRun++;
      if (testErrs == 0) begin
         $display("Test %0d (%s): ok", testsRun, testLabel(testsRun));
      end else begin
         testsFailed++;
         $display("Test %0d (%s): %0d errors", testsRun, testLabel(testsRun), testErrs);
      end
      errTotal += testErrs;
      testErrs = 0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Monitor, sampled mid-cycle
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (!rst_n) begin
         runBusy = 1'b0;
      end else begin
         // Run length from the accepted start to bistDone
         if (runBusy) begin
            runCycles++;
            if (bistDone) begin
               runBusy = 1'b0;
               if (runCycles != runLength) begin
                  $display("Run took %0d cycles from start to done instead of %0d",
                           runCycles, runLength);
                  testErrs++;
               end
            end
         end else if (bistStart) begin
            runBusy   = 1'b1;
            runCycles = 0;
         end
         // Functional access goes out with only the address remapped
         if (bistDone && funcCmd.en) begin
            predictRecord();
            checkValue("memCmd.en", memCmd.en, 64'd1);
            checkValue("memCmd.we", memCmd.we, funcCmd.we);
            checkValue("memCmd.addr", memCmd.addr, expectedAddr(funcCmd.addr));
            checkValue("memCmd.wdata", memCmd.wdata, funcCmd.wdata);
         end
         if (scanShift) begin
            scanBits = {scanBits[chainWd-2:0], scanOut};
         end
         if (checkReq) begin
            closeTest();
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/mbistTop.sv
// MBIST top
// Sequencer, read compare and repair map around one SRAM port; the
// test owns the memory while active, otherwise functional accesses
// pass through with their address remapped

`timescale 1ns/100ps
`default_nettype none

module mbistTop import mbist_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      bistStart,
   output logic      bistDone,
   output logic      repairable,
   output slotCnt_t  usedSlots,
   input  memCmd_t   funcCmd,
   output memCmd_t   memCmd,
   input  bistData_t memRdata,
   input  logic      scanLoad,
   input  logic      scanShift,
   input  logic      scanIn,
   output logic      scanOut
);

   memCmd_t   testCmd;
   memCmd_t   remapCmd;
   bistData_t expData;
   bistAddr_t errAddr;
   bistAddr_t mappedAddr;
   logic      readIssued;
   logic      testActive;
   logic      errStrobe;
   logic      startAccepted;

   // Start pulses during a run must not wipe the record
   assign startAccepted = bistStart && !testActive;

   marchSequencer uSeq (
      .clk        (clk),
      .rst_n      (rst_n),
      .bistStart  (bistStart),
      .testCmd    (testCmd),
      .readIssued (readIssued),
      .expData    (expData),
      .testActive (testActive),
      .bistDone   (bistDone)
   );

   readCompare uCmp (
      .clk        (clk),
      .rst_n      (rst_n),
      .testCmd    (testCmd),
      .readIssued (readIssued),
      .expData    (expData),
      .memRdata   (memRdata),
      .errStrobe  (errStrobe),
      .errAddr    (errAddr)
   );

   repairMap uMap (
      .clk        (clk),
      .rst_n      (rst_n),
      .bistStart  (startAccepted),
      .errStrobe  (errStrobe),
      .errAddr    (errAddr),
      .funcAddr   (funcCmd.addr),
      .mappedAddr (mappedAddr),
      .usedSlots  (usedSlots),
      .repairable (repairable),
      .scanLoad   (scanLoad),
      .scanShift  (scanShift),
      .scanIn     (scanIn),
      .scanOut    (scanOut)
   );

   // Functional command with only the address swapped
   always_comb begin
      remapCmd      = funcCmd;
      remapCmd.addr = mappedAddr;
   end

   assign memCmd = testActive ? testCmd : remapCmd;

endmodule

`default_nettype wire

//--- logic/repairMap.sv
// Repair map
// Records distinct failing rows in four spare slots, redirects
// functional accesses to the spare rows and unloads the record
// through a 36-bit serial scan chain

`timescale 1ns/100ps
`default_nettype none

`include "mbist_consts.svh"

module repairMap import mbist_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      bistStart,
   input  logic      errStrobe,
   input  bistAddr_t errAddr,
   input  bistAddr_t funcAddr,
   output bistAddr_t mappedAddr,
   output slotCnt_t  usedSlots,
   output logic      repairable,
   input  logic      scanLoad,
   input  logic      scanShift,
   input  logic      scanIn,
   output logic      scanOut
);

   localparam int       slotNum   = `MBIST_ERR_LIMIT;
   localparam int       chainWd   = slotNum * `MBIST_ADDR_WD;
   localparam slotCnt_t slotLimit = slotCnt_t'(`MBIST_ERR_LIMIT);

   bistAddr_t [slotNum-1:0] slotAddr;
   logic [chainWd-1:0]      scanReg;
   logic                    errHit;

   ////////////////////////////////////////////////////////////////////////////
   // Slot record
   ////////////////////////////////////////////////////////////////////////////

   // Failing row already held in a used slot
   always_comb begin
      errHit = 1'b0;
      for (int i = 0; i < slotNum; i++) begin
         if (slotCnt_t'(i) < usedSlots && slotAddr[i] == errAddr) begin
            errHit = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slotAddr   <= '0;
         usedSlots  <= '0;
         repairable <= 1'b1;
      end else if (bistStart) begin
         // New run drops the old record
         slotAddr   <= '0;
         usedSlots  <= '0;
         repairable <= 1'b1;
      end else if (errStrobe && !errHit) begin
         if (usedSlots < slotLimit) begin
            slotAddr[usedSlots[1:0]] <= errAddr;
            usedSlots                <= usedSlots + 1'b1;
         end else begin
            // Out of spare rows
            repairable <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Functional remap
   ////////////////////////////////////////////////////////////////////////////

   // Walk down so the lowest matching slot wins
   always_comb begin
      mappedAddr = funcAddr;
      for (int i = slotNum - 1; i >= 0; i--) begin
         if (slotCnt_t'(i) < usedSlots && slotAddr[i] == funcAddr) begin
            mappedAddr = bistAddr_t'(`MBIST_REPAIR_BASE + i);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Scan chain
   ////////////////////////////////////////////////////////////////////////////

   // Slot 3 sits at the top, so it leaves first, MSB first
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         scanReg <= '0;
      end else if (scanLoad) begin
         scanReg <= slotAddr;
      end else if (scanShift) begin
         scanReg <= {scanReg[chainWd-2:0], scanIn};
      end
   end

   assign scanOut = scanReg[chainWd-1];

   slotCountInRange: assert property (@(posedge clk) disable iff (!rst_n)
      usedSlots <= slotLimit);

endmodule

`default_nettype wire

//--- logic/readCompare.sv
// Read compare
// Tags each test read, checks the returned word one cycle later and
// flags a mismatch as a one-cycle error strobe with its address

`timescale 1ns/100ps
`default_nettype none

module readCompare import mbist_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  memCmd_t   testCmd,
   input  logic      readIssued,
   input  bistData_t expData,
   input  bistData_t memRdata,
   output logic      errStrobe,
   output bistAddr_t errAddr
);

   // One stage of read tags, lined up with the data return
   logic      tagValid;
   bistAddr_t tagAddr;
   bistData_t tagExp;
   logic      mismatch;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tagValid  <= 1'b0;
         errStrobe <= 1'b0;
      end else begin
         tagValid  <= readIssued && testCmd.en && !testCmd.we;
         errStrobe <= mismatch;
      end
   end

   // Tag payload and failing address
   always_ff @(posedge clk) begin
      tagAddr <= testCmd.addr;
      tagExp  <= expData;
      if (mismatch) begin
         errAddr <= tagAddr;
      end
   end

   // memRdata is valid in the cycle after the read
   assign mismatch = tagValid && (memRdata != tagExp);

   // A tagged read is always a real memory read
   readTagOnRead: assert property (@(posedge clk) disable iff (!rst_n)
      readIssued |-> (testCmd.en && !testCmd.we));

endmodule

`default_nettype wire

//--- logic/marchSequencer.sv
// March sequencer
// Walks the four march elements over the main rows and issues one
// memory command per cycle, with the expected data for each read

`timescale 1ns/100ps
`default_nettype none

`include "mbist_consts.svh"

module marchSequencer import mbist_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      bistStart,
   output memCmd_t   testCmd,
   output logic      readIssued,
   output bistData_t expData,
   output logic      testActive,
   output logic      bistDone
);

   localparam bistAddr_t lastAddr = `MBIST_ADDR_END;

   marchState_t state;
   bistAddr_t   addr;
   // Drain counts three cycles for the last compare and capture
   logic [1:0]  drainCnt;

   ////////////////////////////////////////////////////////////////////////////
   // State and address counter
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= idle;
         addr     <= '0;
         drainCnt <= '0;
         bistDone <= 1'b0;
      end else begin
         case (state)
            idle: begin
               // Start only taken here, so a pulse mid-test is dropped
               if (bistStart) begin
                  state    <= element0;
                  addr     <= '0;
                  drainCnt <= '0;
                  bistDone <= 1'b0;
               end
            end
            element0: begin
               if (addr == lastAddr) begin
                  state <= element1Read;
                  addr  <= '0;
               end else begin
                  addr <= addr + 1'b1;
               end
            end
            element1Read: state <= element1Write;
            element1Write: begin
               // Descending element begins at the top row
               if (addr == lastAddr) begin
                  state <= element2Read;
               end else begin
                  state <= element1Read;
                  addr  <= addr + 1'b1;
               end
            end
            element2Read: state <= element2Write;
            element2Write: begin
               if (addr == '0) begin
                  state <= element3;
               end else begin
                  state <= element2Read;
                  addr  <= addr - 1'b1;
               end
            end
            element3: begin
               if (addr == lastAddr) begin
                  state <= drain;
                  addr  <= '0;
               end else begin
                  addr <= addr + 1'b1;
               end
            end
            drain: begin
               if (drainCnt == 2'd2) begin
                  state    <= idle;
                  bistDone <= 1'b1;
               end else begin
                  drainCnt <= drainCnt + 1'b1;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Command decode
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      testCmd      = '0;
      testCmd.addr = addr;
      readIssued   = 1'b0;
      expData      = '0;
      case (state)
         // Write zeros
         element0: begin
            testCmd.en = 1'b1;
            testCmd.we = 1'b1;
         end
         element1Read: begin
            testCmd.en = 1'b1;
            readIssued = 1'b1;
         end
         // Write ones
         element1Write: begin
            testCmd.en    = 1'b1;
            testCmd.we    = 1'b1;
            testCmd.wdata = '1;
         end
         element2Read: begin
            testCmd.en = 1'b1;
            readIssued = 1'b1;
            expData    = '1;
         end
         element2Write: begin
            testCmd.en = 1'b1;
            testCmd.we = 1'b1;
         end
         // Final read of zeros
         element3: begin
            testCmd.en = 1'b1;
            readIssued = 1'b1;
         end
         default: ;
      endcase
   end

   assign testActive = (state != idle);

   // Test commands never reach the spare rows
   cmdInMainRows: assert property (@(posedge clk) disable iff (!rst_n)
      testCmd.en |-> (testCmd.addr <= lastAddr));

endmodule

`default_nettype wire

//--- logic/mbist_pkg.sv
// MBIST package
// Shared types for the march sequencer, read compare and repair map

`default_nettype none

`include "mbist_consts.svh"

package mbist_pkg;

   // Row address and data word of the SRAM
   typedef logic [`MBIST_ADDR_WD-1:0] bistAddr_t;
   typedef logic [`MBIST_DATA_WD-1:0] bistData_t;

   // Count of used repair slots, 0 to 4
   typedef logic [2:0] slotCnt_t;

   // One memory command, 43 bits
   typedef struct packed {
      logic      en;
      logic      we;
      bistAddr_t addr;
      bistData_t wdata;
   } memCmd_t;

   // March sequencer states
   typedef enum logic [2:0] {
      idle,
      element0,
      element1Read,
      element1Write,
      element2Read,
      element2Write,
      element3,
      drain
   } marchState_t;

endpackage

`default_nettype wire

//--- include/mbist_consts.svh
// MBIST constants
// Widths, tested row range, spare row base and repair slot count
// for the 512 x 32 single-port SRAM self-test

`ifndef MBIST_CONSTS_SVH
`define MBIST_CONSTS_SVH

// Memory geometry
`define MBIST_ADDR_WD     9
`define MBIST_DATA_WD     32

// Main rows under test run from 0 up to this address
`define MBIST_ADDR_END    9'h1FB

// Spare rows sit above the tested range
`define MBIST_REPAIR_BASE 9'h1FC
`define MBIST_ERR_LIMIT   4

`endif
